//--- compile.f
src/rcPkg.sv
src/ringIf.sv
src/c2fRequest.sv
src/reqRouter.sv
src/f2cBuffer.sv
src/rspArbiter.sv
src/rc.sv
verif/rcTb.sv

//--- Bender.yml
package:
  name: rc

sources:
  - src/rcPkg.sv
  - src/ringIf.sv
  - src/c2fRequest.sv
  - src/reqRouter.sv
  - src/f2cBuffer.sv
  - src/rspArbiter.sv
  - src/rc.sv
  - target: test
    files:
      - verif/rcTb.sv

//--- verif/rcTb.sv
//==============================
// Ring controller testbench
// Random ring traffic, core model,
// scoreboard queues and checks
//==============================
`timescale 1ns/100ps

module rcTb
    import rcPkg::*;
();

    localparam int F2cDepth   = 4;
    localparam int NumSlots   = 300; // Random ring cycles
    localparam int NumCoreReq = 40;
    localparam int NumPackets = 2 * NumSlots + NumCoreReq + F2cDepth + 1;
    localparam int TimeoutCycles = NumPackets * 8 + 200;
    localparam tCoreId OwnCore = 8'h3c;

    // One expected packet with the negedge cycle it is due on
    typedef struct packed {
        logic [31:0] due;
        tRequestor   requestor;
        tOpcode      opcode;
        tAddress     address;
        tData        data;
    } tExpPkt;

    logic      QClk, rst;
    tCoreId    coreId;
    logic      ringReqInValid, ringRspInValid, ringReqOutValid, ringRspOutValid;
    tRequestor ringReqInRequestor, ringRspInRequestor, ringReqOutRequestor, ringRspOutRequestor;
    tOpcode    ringReqInOpcode, ringRspInOpcode, ringReqOutOpcode, ringRspOutOpcode;
    tAddress   ringReqInAddress, ringRspInAddress, ringReqOutAddress, ringRspOutAddress;
    tData      ringReqInData, ringRspInData, ringReqOutData, ringRspOutData;
    logic      c2fReqValid, c2fStall, c2fRspValid, f2cReqValid, f2cRspValid;
    tOpcode    c2fReqOpcode, f2cReqOpcode, f2cRspOpcode;
    tAddress   c2fReqAddress, f2cReqAddress;
    tData      c2fReqData, c2fRspData, f2cReqData, f2cRspData;
    tThreadId  c2fReqThreadId, c2fRspThreadId;

    integer      seed;
    logic [31:0] cycle;         // Bumped on every rising edge
    int          outstanding;   // Local RD and WR not yet seen on ringRspOut
    int          localRun;      // Local responses since last empty slot
    logic        coreHold;      // Core model stops answering
    logic        checkOn;

    tExpPkt fwdReqQ[$], injQ[$], fwdRspQ[$], localRspQ[$], f2cQ[$], c2fQ[$], coreJobs[$];

    rc #(
        .F2cDepth (F2cDepth)
    ) uut (
        .*
    );

    //==============================
    // Clock, cycle count, timeout
    //==============================
    initial begin
        QClk = 1'b0;
        forever #5 QClk = ~QClk;
    end

    always @(posedge QClk) begin
        cycle <= cycle + 1; // Old value seen by stimulus in the same step
        if (cycle > TimeoutCycles) begin
            $display("Timeout: outputs did not drain within %0d cycles", TimeoutCycles);
            $display("Checks failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    //==============================
    // Reference model and checks
    //==============================
    // Returns {consume, forward} for one ring request
    function automatic logic [1:0] predictRing(input tOpcode opc, input tRequestor req,
                                               input tAddress addr, input logic tableFree);
        logic toMe;
        logic home;
        toMe = addr[DataWidth-1 -: CoreIdWidth] == coreId;
        home = req[CoreIdWidth+ThreadIdWidth-1 -: CoreIdWidth] == coreId;
        if (opc == WR_BCAST) begin
            return {1'b1, !home}; // Delivered and stops when back at its source
        end
        if (toMe && tableFree) begin
            return 2'b10;
        end
        return 2'b01; // Other core, or full table sends it round
    endfunction

    // Read data the core model returns for an address
    function automatic tData readData(input tAddress addr);
        return {addr[15:0], ~addr[15:0]} ^ 32'h1357_9bdf;
    endfunction

    task automatic stopNow();
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkPacket(input string what, input tExpPkt exp, input tRequestor r,
                               input tOpcode o, input tAddress a, input tData d);
        if (r !== exp.requestor || o !== exp.opcode || a !== exp.address || d !== exp.data) begin
            $display("ERROR %0t: %s got %h/%s/%h/%h, expected %h/%s/%h/%h", $time, what,
                     r, o.name(), a, d, exp.requestor, exp.opcode.name(), exp.address, exp.data);
            stopNow();
        end
    endtask

    task automatic checkCoreReq(input tExpPkt exp, input tOpcode o, input tAddress a,
                                input tData d);
        if (o !== exp.opcode || a !== exp.address || d !== exp.data) begin
            $display("ERROR %0t: f2cReq got %s/%h/%h, expected %s/%h/%h", $time,
                     o.name(), a, d, exp.opcode.name(), exp.address, exp.data);
            stopNow();
        end
    endtask

    task automatic checkCoreRsp(input tExpPkt exp, input tData d, input tThreadId t);
        if (d !== exp.data || t !== exp.requestor[ThreadIdWidth-1:0]) begin
            $display("ERROR %0t: c2fRsp got %h thread %0d, expected %h thread %0d", $time,
                     d, t, exp.data, exp.requestor[ThreadIdWidth-1:0]);
            stopNow();
        end
    endtask

    task automatic missing(input string what);
        $display("ERROR %0t: %s expected but no valid output", $time, what);
        stopNow();
    endtask

    //==============================
    // Output comparison
    //==============================
    always @(negedge QClk) begin
        if (checkOn) begin
            // Forwarded requests are exactly timed
            if (fwdReqQ.size() > 0 && fwdReqQ[0].due == cycle) begin
                if (!ringReqOutValid) missing("forwarded request");
                checkPacket("fwd request", fwdReqQ.pop_front(), ringReqOutRequestor,
                            ringReqOutOpcode, ringReqOutAddress, ringReqOutData);
            end else if (ringReqOutValid) begin
                if (injQ.size() == 0) begin
                    $display("Unexpected packet on the request ring at %0t", $time);
                    stopNow();
                end
                checkPacket("core request", injQ.pop_front(), ringReqOutRequestor,
                            ringReqOutOpcode, ringReqOutAddress, ringReqOutData);
            end
            // Response channel
            if (!ringRspOutValid) localRun = 0;
            if (fwdRspQ.size() > 0 && fwdRspQ[0].due == cycle) begin
                if (!ringRspOutValid) missing("forwarded response");
                checkPacket("fwd response", fwdRspQ.pop_front(), ringRspOutRequestor,
                            ringRspOutOpcode, ringRspOutAddress, ringRspOutData);
            end else if (ringRspOutValid) begin
                if (localRspQ.size() == 0) begin
                    $display("Unexpected packet on the response ring at %0t", $time);
                    stopNow();
                end
                checkPacket("local response", localRspQ.pop_front(), ringRspOutRequestor,
                            ringRspOutOpcode, ringRspOutAddress, ringRspOutData);
                outstanding--;
                localRun++;
                if (localRun > VentLimit) begin
                    $display("Too many local responses in a row at %0t", $time);
                    stopNow();
                end
            end
            // Core side
            if (f2cQ.size() > 0 && f2cQ[0].due == cycle) begin
                if (!f2cReqValid) missing("f2c request");
                checkCoreReq(f2cQ.pop_front(), f2cReqOpcode, f2cReqAddress, f2cReqData);
            end else if (f2cReqValid) begin
                $display("Unexpected request to the core at %0t", $time);
                stopNow();
            end
            if (c2fQ.size() > 0 && c2fQ[0].due == cycle) begin
                if (!c2fRspValid) missing("c2f response");
                checkCoreRsp(c2fQ.pop_front(), c2fRspData, c2fRspThreadId);
            end else if (c2fRspValid) begin
                $display("Unexpected response to the core at %0t", $time);
                stopNow();
            end
            // Core model job list
            if (f2cReqValid && f2cReqOpcode != WR_BCAST) begin
                coreJobs.push_back({32'd0, tRequestor'(0), f2cReqOpcode, f2cReqAddress,
                                    f2cReqData});
            end
        end
    end

    //==============================
    // Stimulus helpers
    //==============================
    function automatic tCoreId otherCore();
        tCoreId c;
        c = tCoreId'($random(seed));
        if (c == coreId) c = c + 1'b1;
        return c;
    endfunction

    // Called right after a rising edge
    task automatic driveRingReq(input tOpcode opc, input tRequestor req, input tAddress addr,
                                input tData data);
        logic [1:0] outcome;
        tExpPkt     pkt;
        outcome = predictRing(opc, req, addr, outstanding < F2cDepth);
        pkt = {cycle + 32'd3, req, opc, addr, data};
        ringReqInValid     <= 1'b1;
        ringReqInRequestor <= req;
        ringReqInOpcode    <= opc;
        ringReqInAddress   <= addr;
        ringReqInData      <= data;
        if (outcome[1]) begin
            f2cQ.push_back(pkt);
            if (opc != WR_BCAST) begin
                outstanding++;
                localRspQ.push_back({32'd0, req, (opc == RD) ? RD_RSP : WR, addr,
                                     (opc == RD) ? readData(addr) : data});
            end
        end
        if (outcome[0]) fwdReqQ.push_back(pkt);
    endtask

    task automatic driveRingRsp(input tRequestor req, input tOpcode opc, input tAddress addr,
                                input tData data);
        tExpPkt pkt;
        pkt = {cycle + 32'd3, req, opc, addr, data};
        ringRspInValid     <= 1'b1;
        ringRspInRequestor <= req;
        ringRspInOpcode    <= opc;
        ringRspInAddress   <= addr;
        ringRspInData      <= data;
        if (req[CoreIdWidth+ThreadIdWidth-1 -: CoreIdWidth] == coreId) c2fQ.push_back(pkt);
        else fwdRspQ.push_back(pkt);
    endtask

    task automatic randomRingSlot();
        int      kind;
        tOpcode  opc;
        tAddress addr;
        kind = $random(seed) & 7;
        opc  = ($random(seed) & 1) ? WR : RD;
        addr = {otherCore(), 24'($random(seed))};
        ringReqInValid <= 1'b0;
        ringRspInValid <= 1'b0;
        case (kind)
            0, 1, 2: driveRingReq(opc, {otherCore(), 2'($random(seed))}, addr, $random(seed));
            3: begin
                if (outstanding < F2cDepth) addr[DataWidth-1 -: CoreIdWidth] = coreId;
                driveRingReq(opc, {otherCore(), 2'($random(seed))}, addr, $random(seed));
            end
            4: driveRingReq(WR_BCAST, {otherCore(), 2'($random(seed))}, addr, $random(seed));
            5: driveRingReq(WR_BCAST, {coreId, 2'($random(seed))}, addr, $random(seed));
            default: ;
        endcase
        kind = $random(seed) & 3;
        opc  = ($random(seed) & 1) ? WR : RD_RSP;
        if (kind == 0) driveRingRsp({coreId, 2'($random(seed))}, opc, addr, $random(seed));
        else if (kind != 3) driveRingRsp({otherCore(), 2'($random(seed))}, opc, addr,
                                         $random(seed));
    endtask

    //==============================
    // Core model answers in order
    //==============================
    initial begin
        tExpPkt job;
        int     delay;
        @(negedge rst);
        forever begin
            while (coreJobs.size() == 0 || coreHold) @(posedge QClk);
            job   = coreJobs.pop_front();
            delay = $random(seed) & 3;
            repeat (delay) @(posedge QClk);
            @(posedge QClk);
            f2cRspValid  <= 1'b1;
            f2cRspOpcode <= (job.opcode == RD) ? RD_RSP : WR;
            f2cRspData   <= (job.opcode == RD) ? readData(job.address) : job.data;
            @(posedge QClk);
            f2cRspValid  <= 1'b0;
        end
    end

    // Wait until every expectation has been met
    task automatic drain();
        while (fwdReqQ.size() || injQ.size() || fwdRspQ.size() || localRspQ.size()
               || f2cQ.size() || c2fQ.size() || outstanding != 0) begin
            @(posedge QClk);
        end
    endtask

    //==============================
    // Main sequence
    //==============================
    initial begin
        seed = 32'hc4a1;
        cycle = 0;
        outstanding = 0;
        localRun = 0;
        coreHold = 1'b0;
        checkOn = 1'b0;
        coreId = OwnCore;
        rst = 1'b1;
        {ringReqInValid, ringRspInValid, c2fReqValid, f2cRspValid} = '0;
        {ringReqInRequestor, ringRspInRequestor} = '0;
        ringReqInOpcode = RD;
        ringRspInOpcode = RD;
        c2fReqOpcode    = RD;
        f2cRspOpcode    = RD;
        {ringReqInAddress, ringRspInAddress, c2fReqAddress} = '0;
        {ringReqInData, ringRspInData, c2fReqData, f2cRspData} = '0;
        c2fReqThreadId = '0;
        repeat (15) @(posedge QClk);
        @(negedge QClk);
        // Everything idle while reset is held
        if ({ringReqOutValid, ringRspOutValid, c2fRspValid, f2cReqValid, c2fStall} !== 5'b0) begin
            $display("ERROR %0t: valid output or c2fStall high during reset", $time);
            stopNow();
        end
        @(posedge QClk);
        rst <= 1'b0;
        checkOn <= 1'b1;
        fork
            begin
                repeat (NumSlots) begin
                    @(posedge QClk);
                    randomRingSlot();
                end
                @(posedge QClk);
                ringReqInValid <= 1'b0;
                ringRspInValid <= 1'b0;
            end
            begin
                tExpPkt pkt;
                repeat (NumCoreReq) begin
                    @(negedge QClk);
                    while (c2fStall) @(negedge QClk);
                    @(posedge QClk);
                    pkt.requestor = {coreId, 2'($random(seed))};
                    pkt.opcode    = tOpcode'((($random(seed) & 1) ? WR : RD));
                    if (($random(seed) & 3) == 0) pkt.opcode = WR_BCAST;
                    pkt.address   = $random(seed);
                    pkt.data      = $random(seed);
                    injQ.push_back(pkt);
                    c2fReqValid    <= 1'b1;
                    c2fReqOpcode   <= pkt.opcode;
                    c2fReqAddress  <= pkt.address;
                    c2fReqData     <= pkt.data;
                    c2fReqThreadId <= pkt.requestor[ThreadIdWidth-1:0];
                    @(posedge QClk);
                    c2fReqValid    <= 1'b0;
                    // Captured request cannot be on the ring yet
                    @(negedge QClk);
                    if (c2fStall !== 1'b1) begin
                        $display("ERROR %0t: c2fStall low while a core request is held", $time);
                        stopNow();
                    end
                end
            end
        join
        drain();

        // Full table sends the extra local read round again
        coreHold = 1'b1;
        repeat (F2cDepth + 1) begin
            @(posedge QClk);
            driveRingReq(RD, {otherCore(), 2'd1}, {coreId, 24'($random(seed))}, '0);
        end
        @(posedge QClk);
        ringReqInValid <= 1'b0;
        while (f2cQ.size() || fwdReqQ.size()) @(posedge QClk);
        coreHold = 1'b0;
        drain();
        repeat (4) @(posedge QClk);

        // No core request left, so stall must be released
        if (c2fStall === 1'b0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("c2fStall still high with no core request left");
            $display("Checks failed");
            $fatal(1, "stall never released");
        end
    end

endmodule

//--- src/rc.sv
//==============================
// Ring controller top
// Joins one core to the request
// and response rings
//==============================
`timescale 1ns/100ps

module rc
    import rcPkg::*;
#(
    parameter int F2cDepth = 4 // Pending table entries
)(
    input  logic      QClk,
    input  logic      rst,
    input  tCoreId    coreId,
    //==============================
    // Ring side
    //==============================
    input  logic      ringReqInValid,
    input  tRequestor ringReqInRequestor,
    input  tOpcode    ringReqInOpcode,
    input  tAddress   ringReqInAddress,
    input  tData      ringReqInData,
    input  logic      ringRspInValid,
    input  tRequestor ringRspInRequestor,
    input  tOpcode    ringRspInOpcode,
    input  tAddress   ringRspInAddress,
    input  tData      ringRspInData,
    output logic      ringReqOutValid,
    output tRequestor ringReqOutRequestor,
    output tOpcode    ringReqOutOpcode,
    output tAddress   ringReqOutAddress,
    output tData      ringReqOutData,
    output logic      ringRspOutValid,
    output tRequestor ringRspOutRequestor,
    output tOpcode    ringRspOutOpcode,
    output tAddress   ringRspOutAddress,
    output tData      ringRspOutData,
    //==============================
    // Core side
    //==============================
    input  logic      c2fReqValid,
    input  tOpcode    c2fReqOpcode,
    input  tAddress   c2fReqAddress,
    input  tData      c2fReqData,
    input  tThreadId  c2fReqThreadId,
    output logic      c2fStall,
    output logic      c2fRspValid,
    output tData      c2fRspData,
    output tThreadId  c2fRspThreadId,
    output logic      f2cReqValid,
    output tOpcode    f2cReqOpcode,
    output tAddress   f2cReqAddress,
    output tData      f2cReqData,
    input  logic      f2cRspValid,
    input  tOpcode    f2cRspOpcode,
    input  tData      f2cRspData
);

    ringIf coreReq ();   // Held core request toward the ring
    ringIf reqToCore (); // Consumed ring request toward the pending table
    ringIf rspToRing (); // Oldest completed local response

    logic injected;  // Held core request went out this cycle
    logic entryFree; // Pending table can take one more request
    logic rspTaken;  // Local response won the response slot

    // Core requests wait here for a ring slot
    c2fRequest c2fRequest (
        .toRing (coreReq),
        .*
    );

    // Request channel stage, decode and injection
    reqRouter reqRouter (
        .fromCore (coreReq),
        .toCore   (reqToCore),
        .*
    );

    f2cBuffer #(
        .F2cDepth (F2cDepth)
    ) f2cBuffer (
        .fromRing (reqToCore),
        .toRing   (rspToRing),
        .*
    );

    // Response channel stage, delivery and ventilation
    rspArbiter rspArbiter (
        .localRsp (rspToRing),
        .*
    );

endmodule

//--- src/rspArbiter.sv
//==============================
// Response channel arbiter
// Delivers own responses, picks
// forward, bubble or local reply
//==============================
`timescale 1ns/100ps

module rspArbiter
    import rcPkg::*;
(
    input  logic      QClk,
    input  logic      rst,
    input  tCoreId    coreId,
    input  logic      ringRspInValid,
    input  tRequestor ringRspInRequestor,
    input  tOpcode    ringRspInOpcode,
    input  tAddress   ringRspInAddress,
    input  tData      ringRspInData,
    output logic      ringRspOutValid,
    output tRequestor ringRspOutRequestor,
    output tOpcode    ringRspOutOpcode,
    output tAddress   ringRspOutAddress,
    output tData      ringRspOutData,
    ringIf.dst        localRsp,
    output logic      rspTaken,
    output logic      c2fRspValid,
    output tData      c2fRspData,
    output tThreadId  c2fRspThreadId
);

    localparam int VentWidth = $clog2(VentLimit + 1);

    logic                 inValid;
    tRequestor            inRequestor;
    tOpcode               inOpcode;
    tAddress              inAddress;
    tData                 inData;
    logic                 ownRsp, mustFwd, needVent;
    logic [VentWidth-1:0] ventCnt; // Local responses in a row
    tRspSel               rspSel;

    //==============================
    // Input stage
    //==============================
    always_ff @(posedge QClk) begin
        if (rst) begin
            inValid <= 1'b0;
        end else begin
            inValid <= ringRspInValid;
        end
    end

    always_ff @(posedge QClk) begin
        inRequestor <= ringRspInRequestor;
        inOpcode    <= ringRspInOpcode;
        inAddress   <= ringRspInAddress;
        inData      <= ringRspInData;
    end

    // Response belongs to the core that issued the request
    assign ownRsp   = inRequestor[CoreIdWidth+ThreadIdWidth-1 -: CoreIdWidth] == coreId;
    assign mustFwd  = inValid && !ownRsp;
    assign needVent = ventCnt == VentWidth'(VentLimit);

    // Forward first, then bubble, then local
    always_comb begin
        if (mustFwd) begin
            rspSel = RingInput;
        end else if (needVent) begin
            rspSel = BubbleOut;
        end else if (localRsp.valid) begin
            rspSel = F2cResponse;
        end else begin
            rspSel = BubbleOut; // Idle slot
        end
    end

    assign rspTaken = rspSel == F2cResponse;

    // Ventilation counter
    always_ff @(posedge QClk) begin
        if (rst || rspSel == BubbleOut) begin
            ventCnt <= '0;
        end else if (rspSel == F2cResponse) begin
            ventCnt <= ventCnt + 1'b1;
        end
    end

    //==============================
    // Output stage
    //==============================
    always_ff @(posedge QClk) begin
        if (rst) begin
            ringRspOutValid <= 1'b0;
            c2fRspValid     <= 1'b0;
        end else begin
            ringRspOutValid <= rspSel != BubbleOut;
            c2fRspValid     <= inValid && ownRsp;
        end
    end

    always_ff @(posedge QClk) begin
        c2fRspData     <= inData;
        c2fRspThreadId <= inRequestor[ThreadIdWidth-1:0]; // Thread field of requestor
        unique case (rspSel)
            RingInput: begin
                ringRspOutRequestor <= inRequestor;
                ringRspOutOpcode    <= inOpcode;
                ringRspOutAddress   <= inAddress;
                ringRspOutData      <= inData;
            end
            F2cResponse: begin
                ringRspOutRequestor <= localRsp.requestor;
                ringRspOutOpcode    <= localRsp.opcode;
                ringRspOutAddress   <= localRsp.address;
                ringRspOutData      <= localRsp.data;
            end
            default: begin
                ringRspOutRequestor <= '0; // Bubble carries zeros
                ringRspOutOpcode    <= RD;
                ringRspOutAddress   <= '0;
                ringRspOutData      <= '0;
            end
        endcase
    end

endmodule

//--- src/f2cBuffer.sv
//==============================
// Fabric to core buffer
// Pending table of ring requests
// served by the core in order
//==============================
`timescale 1ns/100ps

module f2cBuffer
    import rcPkg::*;
#(
    parameter int F2cDepth = 4 // Power of two
)(
    input  logic    QClk,
    input  logic    rst,
    ringIf.dst      fromRing,
    output logic    entryFree,
    output logic    f2cReqValid,
    output tOpcode  f2cReqOpcode,
    output tAddress f2cReqAddress,
    output tData    f2cReqData,
    input  logic    f2cRspValid,
    input  tOpcode  f2cRspOpcode,
    input  tData    f2cRspData,
    ringIf.src      toRing,
    input  logic    rspTaken
);

    localparam int PtrWidth = (F2cDepth > 1) ? $clog2(F2cDepth) : 1;

    typedef logic [PtrWidth-1:0] tPtr;

    tPtr                 allocPtr; // Next entry for a ring request
    tPtr                 rspPtr;   // Next entry the core answers
    tPtr                 freePtr;  // Oldest entry, next one out
    logic [F2cDepth-1:0] entryValid;
    logic [F2cDepth-1:0] entryDone; // Core response stored
    tRequestor           entryRequestor [F2cDepth];
    tAddress             entryAddress [F2cDepth];
    tOpcode              entryOpcode [F2cDepth];
    tData                entryData [F2cDepth];
    logic                allocate;

    function automatic tPtr nextPtr(input tPtr ptr);
        return (ptr == tPtr'(F2cDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Broadcast writes get no core answer
    assign allocate  = fromRing.valid && (fromRing.opcode != WR_BCAST);
    assign entryFree = !entryValid[allocPtr];

    //==============================
    // Table control
    //==============================
    always_ff @(posedge QClk) begin
        if (rst) begin
            allocPtr   <= '0;
            rspPtr     <= '0;
            freePtr    <= '0;
            entryValid <= '0;
            entryDone  <= '0;
        end else begin
            if (rspTaken) begin
                entryValid[freePtr] <= 1'b0;
                entryDone[freePtr]  <= 1'b0;
                freePtr             <= nextPtr(freePtr);
            end
            if (f2cRspValid) begin
                entryDone[rspPtr] <= 1'b1; // Answers come in request order
                rspPtr            <= nextPtr(rspPtr);
            end
            if (allocate) begin
                entryValid[allocPtr] <= 1'b1;
                allocPtr             <= nextPtr(allocPtr);
            end
        end
    end

    // Entry payload
    always_ff @(posedge QClk) begin
        if (allocate) begin
            entryRequestor[allocPtr] <= fromRing.requestor;
            entryAddress[allocPtr]   <= fromRing.address;
        end
        if (f2cRspValid) begin
            entryOpcode[rspPtr] <= f2cRspOpcode;
            entryData[rspPtr]   <= f2cRspData;
        end
    end

    //==============================
    // Core request register
    //==============================
    always_ff @(posedge QClk) begin
        if (rst) begin
            f2cReqValid <= 1'b0;
        end else begin
            f2cReqValid <= fromRing.valid;
        end
    end

    always_ff @(posedge QClk) begin
        if (fromRing.valid) begin
            f2cReqOpcode  <= fromRing.opcode;
            f2cReqAddress <= fromRing.address;
            f2cReqData    <= fromRing.data;
        end
    end

    // Oldest entry offered once answered
    assign toRing.valid     = entryValid[freePtr] && entryDone[freePtr];
    assign toRing.requestor = entryRequestor[freePtr];
    assign toRing.opcode    = entryOpcode[freePtr];
    assign toRing.address   = entryAddress[freePtr];
    assign toRing.data      = entryData[freePtr];

endmodule

//--- src/reqRouter.sv
//==============================
// Request channel router
// Consumes, forwards or injects
// one packet per ring slot
//==============================
`timescale 1ns/100ps

module reqRouter
    import rcPkg::*;
(
    input  logic      QClk,
    input  logic      rst,
    input  tCoreId    coreId,
    input  logic      ringReqInValid,
    input  tRequestor ringReqInRequestor,
    input  tOpcode    ringReqInOpcode,
    input  tAddress   ringReqInAddress,
    input  tData      ringReqInData,
    output logic      ringReqOutValid,
    output tRequestor ringReqOutRequestor,
    output tOpcode    ringReqOutOpcode,
    output tAddress   ringReqOutAddress,
    output tData      ringReqOutData,
    ringIf.dst        fromCore,
    output logic      injected,
    ringIf.src        toCore,
    input  logic      entryFree
);

    logic      inValid;
    tRequestor inRequestor;
    tOpcode    inOpcode;
    tAddress   inAddress;
    tData      inData;
    logic      dstMatch, isBcast, bcastHome, takeLocal;
    logic      consume, forward;

    //==============================
    // Input stage
    //==============================
    always_ff @(posedge QClk) begin
        if (rst) begin
            inValid <= 1'b0;
        end else begin
            inValid <= ringReqInValid;
        end
    end

    always_ff @(posedge QClk) begin
        inRequestor <= ringReqInRequestor;
        inOpcode    <= ringReqInOpcode;
        inAddress   <= ringReqInAddress;
        inData      <= ringReqInData;
    end

    //==============================
    // Destination decode
    //==============================
    assign dstMatch  = inAddress[DataWidth-1 -: CoreIdWidth] == coreId;
    assign isBcast   = inOpcode == WR_BCAST;
    assign bcastHome = inRequestor[CoreIdWidth+ThreadIdWidth-1 -: CoreIdWidth] == coreId;
    assign takeLocal = dstMatch && entryFree; // Full table sends it round again

    // Broadcast is always delivered and stops back at its source
    assign consume = inValid && (isBcast || takeLocal);
    assign forward = inValid && (isBcast ? !bcastHome : !takeLocal);

    assign toCore.valid     = consume;
    assign toCore.requestor = inRequestor;
    assign toCore.opcode    = inOpcode;
    assign toCore.address   = inAddress;
    assign toCore.data      = inData;

    // Forwarded traffic always wins the slot
    assign injected = fromCore.valid && !forward;

    //==============================
    // Output stage
    //==============================
    always_ff @(posedge QClk) begin
        if (rst) begin
            ringReqOutValid <= 1'b0;
        end else begin
            ringReqOutValid <= forward || fromCore.valid;
        end
    end

    always_ff @(posedge QClk) begin
        if (forward) begin
            ringReqOutRequestor <= inRequestor;
            ringReqOutOpcode    <= inOpcode;
            ringReqOutAddress   <= inAddress;
            ringReqOutData      <= inData;
        end else begin
            ringReqOutRequestor <= fromCore.requestor; // Empty slot or injection
            ringReqOutOpcode    <= fromCore.opcode;
            ringReqOutAddress   <= fromCore.address;
            ringReqOutData      <= fromCore.data;
        end
    end

endmodule

//--- src/c2fRequest.sv
//==============================
// Core request holder
// One core request waits here
// until it goes onto the ring
//==============================
`timescale 1ns/100ps

module c2fRequest
    import rcPkg::*;
(
    input  logic     QClk,
    input  logic     rst,
    input  tCoreId   coreId,
    input  logic     c2fReqValid,
    input  tOpcode   c2fReqOpcode,
    input  tAddress  c2fReqAddress,
    input  tData     c2fReqData,
    input  tThreadId c2fReqThreadId,
    output logic     c2fStall,
    ringIf.src       toRing,
    input  logic     injected
);

    logic      held;          // Request waiting for a slot
    logic      capture;
    tRequestor heldRequestor;
    tOpcode    heldOpcode;
    tAddress   heldAddress;
    tData      heldData;

    // Only one request in flight
    assign capture = c2fReqValid && !held;

    always_ff @(posedge QClk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (capture) begin
            held <= 1'b1;
        end else if (injected) begin
            held <= 1'b0; // Slot taken by reqRouter
        end
    end

    always_ff @(posedge QClk) begin
        if (capture) begin
            heldRequestor <= {coreId, c2fReqThreadId}; // Own core, issuing thread
            heldOpcode    <= c2fReqOpcode;
            heldAddress   <= c2fReqAddress;
            heldData      <= c2fReqData;
        end
    end

    assign c2fStall = held; // Core keeps its inputs while high

    assign toRing.valid     = held;
    assign toRing.requestor = heldRequestor;
    assign toRing.opcode    = heldOpcode;
    assign toRing.address   = heldAddress;
    assign toRing.data      = heldData;

endmodule

//--- src/ringIf.sv
//==============================
// Ring packet bundle
// One packet between internal blocks
//==============================
`timescale 1ns/100ps

interface ringIf
    import rcPkg::*;
();

    logic      valid;     // Packet present this cycle
    tRequestor requestor; // Issuing core and thread
    tOpcode    opcode;
    tAddress   address;
    tData      data;

    // Sending side
    modport src (
        output valid, requestor, opcode, address, data
    );

    // Receiving side
    modport dst (
        input valid, requestor, opcode, address, data
    );

endinterface

//--- src/rcPkg.sv
//==============================
// Ring controller package
// Ring widths, packet field types,
// opcodes and the response select
//==============================
package rcPkg;

    //==============================
    // Widths
    //==============================
    localparam int DataWidth     = 32; // Data and address
    localparam int CoreIdWidth   = 8;  // Core number in address top bits
    localparam int ThreadIdWidth = 2;  // Thread number inside a core

    // Local responses in a row before one bubble is forced
    localparam int VentLimit = 3;

    //==============================
    // Packet fields
    //==============================
    typedef logic [DataWidth-1:0]     tData;
    typedef logic [DataWidth-1:0]     tAddress;  // Top CoreIdWidth bits name the target
    typedef logic [CoreIdWidth-1:0]   tCoreId;
    typedef logic [ThreadIdWidth-1:0] tThreadId;

    // Core number then thread number
    typedef logic [CoreIdWidth+ThreadIdWidth-1:0] tRequestor;

    typedef enum logic [1:0] {
        RD       = 2'b00, // Read request
        RD_RSP   = 2'b01, // Read response
        WR       = 2'b10, // Write request and its response
        WR_BCAST = 2'b11  // Write to every core on the ring
    } tOpcode;

    //==============================
    // Response output choice
    //==============================
    typedef enum logic [1:0] {
        BubbleOut   = 2'b00, // Empty slot
        RingInput   = 2'b01, // Forwarded ring response
        F2cResponse = 2'b10  // Local core response
    } tRspSel;

endpackage
